//--- rtl/wb_bus_pkg.sv
package wb_bus_pkg;

  localparam int num_slaves = 3;

  // slot of each slave in the strobe, ack and data vectors.
  localparam int reg_slot  = 0;
  localparam int ram_slot  = 1;
  localparam int fifo_slot = 2;

  typedef logic [31:0] word_t;

  // inclusive byte ranges, indexed by slot.
  localparam word_t slave_base [num_slaves] = '{
    32'h0000_0000,
    32'h0000_1000,
    32'h0000_2000
  };
  localparam word_t slave_high [num_slaves] = '{
    32'h0000_003f,
    32'h0000_13ff,
    32'h0000_2003
  };

  localparam int timeout_cycles  = 16;  // wait cycles before the router gives up.
  localparam int reg_words       = 16;
  localparam int ram_words       = 256;
  localparam int ram_wait_cycles = 2;   // ram latency used in the subsystem.
  localparam int fifo_depth      = 8;

  // one request, as issued by the master and forwarded to the slaves.
  typedef struct packed {
    logic       we;   // high for a write.
    logic [3:0] sel;  // byte lanes of dat.
    word_t      adr;  // byte address, slave offset on the slave side.
    word_t      dat;  // write data.
  } wb_req_t;

  // read data of every slave, indexed by slot.
  typedef word_t [num_slaves-1:0] slave_dat_t;

endpackage

//--- rtl/wb_timeout.sv
`timescale 1ns/1ps

module wb_timeout #(
  parameter int timeout_cycles = 16
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  output logic expired_o
);

  localparam int cnt_w = $clog2(timeout_cycles + 1);

  logic [cnt_w-1:0] count;

  // counts cycles out of reset and stops at the limit.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count <= '0;
    end else if (!expired_o) begin
      count <= count + 1'b1;
    end
  end

  assign expired_o = (count == cnt_w'(timeout_cycles));  // stays high until reset.

endmodule

//--- rtl/wbs_arbiter.sv
`timescale 1ns/1ps

module wbs_arbiter import wb_bus_pkg::*; (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wbm_cyc_i,
  input  logic                  wbm_stb_i,
  input  wb_req_t               wbm_req_i,
  output word_t                 wbm_dat_o,
  output logic                  wbm_ack_o,
  output logic                  wbm_err_o,
  output logic [num_slaves-1:0] wbs_stb_o,
  output wb_req_t               wbs_req_o,
  input  slave_dat_t            wbs_dat_i,
  input  logic [num_slaves-1:0] wbs_ack_i
);

  typedef enum logic {
    st_idle,
    st_wait
  } state_t;

  state_t                state;
  logic [num_slaves-1:0] wbs_sel;     // decoded match of the current request.
  logic [num_slaves-1:0] wbs_active;  // slave that owns the open transaction.
  word_t                 adr_off;
  word_t                 adr_q;
  logic                  tmo_rst;
  logic                  timeout;

  assign tmo_rst = wb_rst_i | (state != st_wait);  // runs only while waiting.

  wb_timeout #(
    .timeout_cycles(timeout_cycles)
  ) u_timeout (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (tmo_rst),
    .expired_o(timeout)
  );

  // address map compare, one bit per slave.
  always_comb begin
    wbs_sel = '0;
    for (int i = 0; i < num_slaves; i++) begin
      wbs_sel[i] = (wbm_req_i.adr >= slave_base[i]) && (wbm_req_i.adr <= slave_high[i]);
    end
  end

  always_comb begin
    adr_off = wbm_req_i.adr;
    for (int i = 0; i < num_slaves; i++) begin
      if (wbs_sel[i]) begin
        adr_off = wbm_req_i.adr - slave_base[i];  // slaves see offsets from zero.
      end
    end
  end

  // the master holds we, sel and dat, so only the address is registered.
  always_comb begin
    wbs_req_o     = wbm_req_i;
    wbs_req_o.adr = adr_q;
  end

  always_comb begin
    wbm_dat_o = '0;
    for (int i = 0; i < num_slaves; i++) begin
      if (wbs_active[i]) begin
        wbm_dat_o = wbs_dat_i[i];
      end
    end
  end

  assign wbm_ack_o = (state == st_wait) && ((wbs_ack_i & wbs_active) != '0);

  always_ff @(posedge wb_clk_i) begin
    if (state == st_idle && wbm_cyc_i && wbm_stb_i) begin
      adr_q <= adr_off;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    wbs_stb_o <= '0;   // strobe and error are single-cycle pulses.
    wbm_err_o <= 1'b0;
    if (wb_rst_i) begin
      state      <= st_idle;
      wbs_active <= '0;
    end else begin
      case (state)
        st_idle: begin
          // a pending error means the master still holds the old request.
          if (wbm_cyc_i && wbm_stb_i && !wbm_err_o) begin
            if (wbs_sel == '0) begin
              wbm_err_o <= 1'b1;  // unmapped address.
            end else begin
              wbs_active <= wbs_sel;  // kept after the transaction because the ack mux reads it.
              wbs_stb_o  <= wbs_sel;
              state      <= st_wait;
            end
          end
        end
        st_wait: begin
          if ((wbs_ack_i & wbs_active) != '0) begin
            state <= st_idle;
          end else if (timeout) begin
            wbm_err_o <= 1'b1;  // slave never answered.
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_sel_onehot0: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(wbs_sel));

  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_ack_o && wbm_err_o));

endmodule

//--- rtl/wb_reg_slave.sv
`timescale 1ns/1ps

module wb_reg_slave import wb_bus_pkg::*; (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbs_stb_i,
  input  wb_req_t wbs_req_i,
  output word_t   wbs_dat_o,
  output logic    wbs_ack_o
);

  word_t      regs [reg_words];
  logic [3:0] idx;

  assign idx = wbs_req_i.adr[5:2];  // word index within the bank.

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < reg_words; i++) begin
        regs[i] <= '0;
      end
    end else if (wbs_stb_i && wbs_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wbs_req_i.sel[b]) begin
          regs[idx][8*b +: 8] <= wbs_req_i.dat[8*b +: 8];  // only the selected lanes.
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wbs_stb_i && !wbs_req_i.we) begin
      wbs_dat_o <= regs[idx];  // whole word regardless of sel.
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= wbs_stb_i;  // every access completes in one cycle.
    end
  end

  // the router strobes once per transaction, so acks cannot run back to back.
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbs_ack_o |=> !wbs_ack_o);

endmodule

//--- rtl/wb_ram_slave.sv
`timescale 1ns/1ps

module wb_ram_slave import wb_bus_pkg::*; #(
  parameter int ram_wait = 2
) (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbs_stb_i,
  input  wb_req_t wbs_req_i,
  output word_t   wbs_dat_o,
  output logic    wbs_ack_o
);

  localparam int cnt_w = $clog2(ram_wait + 1);

  word_t            mem [ram_words];
  logic [7:0]       idx;
  logic [7:0]       idx_q;  // word of the pending access.
  logic [cnt_w-1:0] cnt;    // cycles left before the ack.

  assign idx = wbs_req_i.adr[9:2];

  // writes land at the strobe, the ack follows later.
  always_ff @(posedge wb_clk_i) begin
    if (wbs_stb_i && wbs_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wbs_req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= wbs_req_i.dat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wbs_stb_i) begin
      idx_q <= idx;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    wbs_ack_o <= 1'b0;
    if (wb_rst_i) begin
      cnt <= '0;
    end else if (wbs_stb_i) begin
      if (ram_wait == 1) begin
        wbs_ack_o <= 1'b1;  // no extra wait, answer like a register.
        wbs_dat_o <= mem[idx];
      end else begin
        cnt <= cnt_w'(ram_wait - 1);
      end
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
      if (cnt == cnt_w'(1)) begin
        wbs_ack_o <= 1'b1;
        wbs_dat_o <= mem[idx_q];  // data is read on the way into the ack cycle.
      end
    end
  end

endmodule

//--- rtl/wb_fifo_slave.sv
`timescale 1ns/1ps

module wb_fifo_slave import wb_bus_pkg::*; (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbs_stb_i,
  input  wb_req_t wbs_req_i,
  output word_t   wbs_dat_o,
  output logic    wbs_ack_o
);

  localparam int ptr_w = $clog2(fifo_depth);

  word_t            mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;  // occupancy, 0 to fifo_depth.
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count == (ptr_w + 1)'(fifo_depth));
  assign empty = (count == '0);

  // requests that cannot be served fall through and get no ack.
  assign push = wbs_stb_i && wbs_req_i.we && !full;
  assign pop  = wbs_stb_i && !wbs_req_i.we && !empty;

  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      mem[wr_ptr] <= wbs_req_i.dat;  // whole word, byte selects do not apply.
    end
    if (pop) begin
      wbs_dat_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= push || pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop never share a cycle, the bus carries one request.
      if (push) begin
        count <= count + 1'b1;
      end else if (pop) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    count <= (ptr_w + 1)'(fifo_depth));

endmodule

//--- rtl/wb_subsystem_top.sv
`timescale 1ns/1ps

module wb_subsystem_top import wb_bus_pkg::*; (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbm_cyc_i,
  input  logic    wbm_stb_i,
  input  wb_req_t wbm_req_i,
  output word_t   wbm_dat_o,
  output logic    wbm_ack_o,
  output logic    wbm_err_o
);

  logic [num_slaves-1:0] wbs_stb;
  logic [num_slaves-1:0] wbs_ack;
  wb_req_t               wbs_req;  // shared by all slaves, the strobe picks one.
  slave_dat_t            wbs_dat;

  wbs_arbiter u_arbiter (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbm_cyc_i(wbm_cyc_i),
    .wbm_stb_i(wbm_stb_i),
    .wbm_req_i(wbm_req_i),
    .wbm_dat_o(wbm_dat_o),
    .wbm_ack_o(wbm_ack_o),
    .wbm_err_o(wbm_err_o),
    .wbs_stb_o(wbs_stb),
    .wbs_req_o(wbs_req),
    .wbs_dat_i(wbs_dat),
    .wbs_ack_i(wbs_ack)
  );

  wb_reg_slave u_reg (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbs_stb_i(wbs_stb[reg_slot]),
    .wbs_req_i(wbs_req),
    .wbs_dat_o(wbs_dat[reg_slot]),
    .wbs_ack_o(wbs_ack[reg_slot])
  );

  wb_ram_slave #(
    .ram_wait(ram_wait_cycles)
  ) u_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbs_stb_i(wbs_stb[ram_slot]),
    .wbs_req_i(wbs_req),
    .wbs_dat_o(wbs_dat[ram_slot]),
    .wbs_ack_o(wbs_ack[ram_slot])
  );

  wb_fifo_slave u_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbs_stb_i(wbs_stb[fifo_slot]),
    .wbs_req_i(wbs_req),
    .wbs_dat_o(wbs_dat[fifo_slot]),
    .wbs_ack_o(wbs_ack[fifo_slot])
  );

endmodule

//--- tests/tb_wb_subsystem.sv
`timescale 1ns/1ps

module tb_wb_subsystem import wb_bus_pkg::*; ();

  localparam string vec_file     = "tests/bus_tests.txt";
  localparam int    reset_cycles = 16;

  logic    wb_clk;
  logic    wb_rst;
  logic    wbm_cyc;
  logic    wbm_stb;
  wb_req_t wbm_req;
  word_t   wbm_dat;
  logic    wbm_ack;
  logic    wbm_err;

  string      vec_name  [$];
  bit         vec_write [$];
  word_t      vec_adr   [$];
  word_t      vec_dat   [$];
  logic [3:0] vec_sel   [$];
  word_t      vec_exp   [$];
  bit         vec_err   [$];  // high when the bus must answer with an error.

  int errors;
  int checks;
  bit vectors_loaded;

  wb_subsystem_top dut (
    .wb_clk_i (wb_clk),
    .wb_rst_i (wb_rst),
    .wbm_cyc_i(wbm_cyc),
    .wbm_stb_i(wbm_stb),
    .wbm_req_i(wbm_req),
    .wbm_dat_o(wbm_dat),
    .wbm_ack_o(wbm_ack),
    .wbm_err_o(wbm_err)
  );

  always #50 wb_clk = ~wb_clk;

  function automatic string outcome_name(input bit is_err);
    return is_err ? "err" : "ack";
  endfunction

  task automatic load_vectors();
    int         fd;
    int         n;
    int         line_no;
    string      line;
    string      name;
    string      op;
    string      outcome;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
    word_t      exp_dat;
    fd = $fopen(vec_file, "r");
    if (fd == 0) begin
      $display("cannot open the vector file %s", vec_file);
      errors++;
      return;
    end
    line_no = 0;
    while (1) begin
      n = $fgets(line, fd);
      if (n == 0) break;
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") continue;  // comment or blank line.
      n = $sscanf(line, "%s %s %h %h %h %h %s", name, op, adr, dat, sel, exp_dat, outcome);
      if (n != 7 || !(op == "read" || op == "write") ||
          !(outcome == "ack" || outcome == "err")) begin
        $display("malformed vector on line %0d of %s", line_no, vec_file);
        errors++;
        continue;
      end
      vec_name.push_back(name);
      vec_write.push_back(op == "write");
      vec_adr.push_back(adr);
      vec_dat.push_back(dat);
      vec_sel.push_back(sel);
      vec_exp.push_back(exp_dat);
      vec_err.push_back(outcome == "err");
    end
    $fclose(fd);
  endtask

  // called right after a falling edge and returns once the strobe has been low one cycle.
  task automatic run_vector(input int i);
    bit    got_err;
    word_t got_dat;
    wbm_req.we  = vec_write[i];
    wbm_req.sel = vec_sel[i];
    wbm_req.adr = vec_adr[i];
    wbm_req.dat = vec_dat[i];
    wbm_cyc     = 1'b1;
    wbm_stb     = 1'b1;
    do begin
      @(negedge wb_clk);
    end while (!wbm_ack && !wbm_err);
    got_err = wbm_err;
    got_dat = wbm_dat;
    wbm_cyc = 1'b0;
    wbm_stb = 1'b0;
    @(negedge wb_clk);
    checks++;
    assert (got_err == vec_err[i]) else begin
      errors++;
      $display("[ERROR] %s outcome expected %s actual %s", vec_name[i],
               outcome_name(vec_err[i]), outcome_name(got_err));
    end
    if (!vec_write[i] && !vec_err[i] && !got_err) begin
      checks++;
      assert (got_dat == vec_exp[i]) else begin
        errors++;
        $display("[ERROR] %s read data expected %08h actual %08h", vec_name[i],
                 vec_exp[i], got_dat);
      end
    end
  endtask

  initial begin
    wb_clk  = 1'b0;
    wb_rst  = 1'b1;
    wbm_cyc = 1'b0;
    wbm_stb = 1'b0;
    wbm_req = '0;
    errors  = 0;
    checks  = 0;
    load_vectors();
    if (vec_name.size() == 0) begin
      $display("no usable vectors were read from %s", vec_file);
      errors++;
    end
    vectors_loaded = 1'b1;
    repeat (reset_cycles) @(negedge wb_clk);
    wb_rst = 1'b0;
    // an idle bus must stay quiet.
    repeat (4) begin
      @(negedge wb_clk);
      checks++;
      assert (!wbm_ack && !wbm_err) else begin
        errors++;
        $display("ack or err went high while no request was pending");
      end
    end
    foreach (vec_name[i]) begin
      run_vector(i);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    longint limit_ns;
    wait (vectors_loaded);
    limit_ns = 64'd100 * (64'(reset_cycles + 4) + 64'(vec_name.size()) * 64'(timeout_cycles + 10));
    #(limit_ns);
    $display("the run hung, no bus response within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule

//--- tests/bus_tests.txt
# name op addr wdata sel exp_rdata outcome, all numbers in hex.
# exp_rdata is checked only on reads that end in ack.
rst_reg_rd0     read  00000000 00000000 f 00000000 ack
rst_reg_rd15    read  0000003c 00000000 f 00000000 ack
reg_full_wr1    write 00000004 12345678 f 00000000 ack
reg_byte0_wr1   write 00000004 000000aa 1 00000000 ack
reg_byte2_wr1   write 00000004 00cc0000 4 00000000 ack
reg_merge_rd1   read  00000004 00000000 f 12cc56aa ack
reg_full_wr15   write 0000003c deadbeef f 00000000 ack
reg_byte31_wr15 write 0000003c 11002200 a 00000000 ack
reg_merge_rd15  read  0000003c 00000000 f 11ad22ef ack
ram_wr_0        write 00001000 a5a5a5a5 f 00000000 ack
ram_wr_1        write 00001004 01020304 f 00000000 ack
ram_wr_128      write 00001200 cafef00d f 00000000 ack
ram_wr_255      write 000013fc 5a5a0001 f 00000000 ack
ram_rd_0        read  00001000 00000000 f a5a5a5a5 ack
ram_rd_1        read  00001004 00000000 f 01020304 ack
ram_rd_128      read  00001200 00000000 f cafef00d ack
ram_rd_255      read  000013fc 00000000 f 5a5a0001 ack
fifo_push_a     write 00002000 11111111 f 00000000 ack
fifo_push_b     write 00002000 22222222 f 00000000 ack
fifo_push_c     write 00002000 33333333 f 00000000 ack
fifo_pop_a      read  00002000 00000000 f 11111111 ack
fifo_pop_b      read  00002000 00000000 f 22222222 ack
fifo_pop_c      read  00002000 00000000 f 33333333 ack
unmap_rd_0800   read  00000800 00000000 f 00000000 err
unmap_wr_0800   write 00000800 0badc0de f 00000000 err
unmap_rd_3000   read  00003000 00000000 f 00000000 err
unmap_wr_3000   write 00003000 0badc0de f 00000000 err
fifo_empty_rd   read  00002000 00000000 f 00000000 err
fifo_fill_1     write 00002000 f0000001 f 00000000 ack
fifo_fill_2     write 00002000 f0000002 f 00000000 ack
fifo_fill_3     write 00002000 f0000003 f 00000000 ack
fifo_fill_4     write 00002000 f0000004 f 00000000 ack
fifo_fill_5     write 00002000 f0000005 f 00000000 ack
fifo_fill_6     write 00002000 f0000006 f 00000000 ack
fifo_fill_7     write 00002000 f0000007 f 00000000 ack
fifo_fill_8     write 00002000 f0000008 f 00000000 ack
fifo_full_wr    write 00002000 f0000009 f 00000000 err
fifo_after_full read  00002000 00000000 f f0000001 ack

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_wb_subsystem
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

//--- verilog.f
rtl/wb_bus_pkg.sv
rtl/wb_timeout.sv
rtl/wbs_arbiter.sv
rtl/wb_reg_slave.sv
rtl/wb_ram_slave.sv
rtl/wb_fifo_slave.sv
rtl/wb_subsystem_top.sv
tests/tb_wb_subsystem.sv
